//--- common/dmem_cfg_pkg.sv
/*
 * Data memory geometry constants
 * APB address map and data widths
 * Host port FSM state codes
 */

package dmem_cfg_pkg;

    // Memory geometry
    localparam int DMEM_AW    = 8;                 // Byte address width
    localparam int DMEM_DEPTH = 2 ** DMEM_AW;      // Bytes
    localparam int DMEM_WORDS = DMEM_DEPTH / 4;    // Words per byte lane
    localparam int DMEM_WAW   = DMEM_AW - 2;       // Word address width

    localparam int NB_BYTE = 8;
    localparam int NB_WORD = 32;

    // APB side
    localparam int APB_AW = 12;
    localparam int APB_DW = 32;
    localparam int APB_SW = APB_DW / NB_BYTE;      // Strobe bits

    // Host port FSM
    localparam logic [1:0] APB_ST_IDLE   = 2'd0;
    localparam logic [1:0] APB_ST_WAIT   = 2'd1;   // Access phase, waiting on grant
    localparam logic [1:0] APB_ST_RD_RET = 2'd2;   // Read data back from RAM

endpackage

//--- common/rv_mem_pkg.sv
/*
 * RISC-V load and store funct3 encodings
 * Access size field values
 * Packed union giving byte and halfword views of a word
 */

package rv_mem_pkg;

    // Loads
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // Stores
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // funct3[1:0] gives the access size for loads and stores alike
    localparam logic [1:0] SZ_BYTE = 2'b00;
    localparam logic [1:0] SZ_HALF = 2'b01;
    localparam logic [1:0] SZ_WORD = 2'b10;

    // One memory word, seen as lanes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  b;   // Byte lanes, index is byte offset
        logic [1:0][15:0] h;   // Halfwords, index is offset bit 1
    } mem_word_u;

endpackage

//--- hw/dmem/dmem_lsu_decode.sv
/*
 * Core load/store decoder
 * Lane enables, lane-aligned write data, misalignment flag
 */

`timescale 1ns/1ps

module dmem_lsu_decode
    import dmem_cfg_pkg::*, rv_mem_pkg::*;
(
    input  logic                clk,
    input  logic                i_rst,
    input  logic                i_core_ren,
    input  logic                i_core_wen,
    input  logic [2:0]          i_core_funct3,
    input  logic [DMEM_AW-1:0]  i_core_addr,
    input  logic [NB_WORD-1:0]  i_core_wdata,
    output logic [3:0]          o_wr_lanes,
    output mem_word_u           o_wr_data,
    output logic [DMEM_WAW-1:0] o_word_addr,
    output logic                o_rd_req,
    output logic [1:0]          o_byte_off,
    output logic [2:0]          o_ld_funct3,
    output logic                o_misaligned
);

    logic [1:0] off;
    logic [1:0] size;
    logic       mis;

    assign off  = i_core_addr[1:0];
    assign size = i_core_funct3[1:0];

    // Halfword needs bit 0 clear, word needs offset 00
    assign mis = ((size == SZ_HALF) && off[0]) ||
                 ((size == SZ_WORD) && (off != 2'b00));

    assign o_word_addr = i_core_addr[DMEM_AW-1:2];
    assign o_byte_off  = off;
    assign o_ld_funct3 = i_core_funct3;
    assign o_rd_req    = i_core_ren && !mis;

    always_comb begin
        o_wr_data  = '0;
        o_wr_lanes = 4'b0000;
        case (i_core_funct3)
            F3_SB: begin
                o_wr_data.b[off] = i_core_wdata[NB_BYTE-1:0];
                o_wr_lanes       = 4'b0001 << off;
            end
            F3_SH: begin
                o_wr_data.h[off[1]] = i_core_wdata[2*NB_BYTE-1:0];
                o_wr_lanes          = 4'b0011 << {off[1], 1'b0};
            end
            F3_SW: begin
                o_wr_data  = i_core_wdata;
                o_wr_lanes = 4'b1111;
            end
            default: ;  // Unknown store size writes nothing
        endcase
        if (!i_core_wen || mis) begin
            o_wr_lanes = 4'b0000;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_misaligned <= 1'b0;
        end else begin
            o_misaligned <= (i_core_ren || i_core_wen) && mis;
        end
    end

    // Core never loads and stores in one cycle
    a_ren_wen_excl: assert property (@(posedge clk) disable iff (i_rst)
        !(i_core_ren && i_core_wen));

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (i_rst)
        !(o_rd_req && (|o_wr_lanes)));

endmodule

//--- hw/dmem/dmem_apb_port.sv
/*
 * APB4 slave for host access to the data memory
 * Word requests with byte strobes, slave error when out of range
 */

`timescale 1ns/1ps

module dmem_apb_port
    import dmem_cfg_pkg::*;
(
    input  logic                clk,
    input  logic                i_rst,
    input  logic                i_psel,
    input  logic                i_penable,
    input  logic                i_pwrite,
    input  logic [APB_AW-1:0]   i_paddr,
    input  logic [APB_DW-1:0]   i_pwdata,
    input  logic [APB_SW-1:0]   i_pstrb,
    input  logic                i_grant,
    input  logic [NB_WORD-1:0]  i_host_rdata,
    output logic [APB_DW-1:0]   o_prdata,
    output logic                o_pready,
    output logic                o_pslverr,
    output logic                o_host_req,
    output logic                o_host_we,
    output logic [DMEM_WAW-1:0] o_host_waddr,
    output logic [APB_DW-1:0]   o_host_wdata,
    output logic [APB_SW-1:0]   o_host_strb
);

    logic [1:0] state;
    logic [1:0] state_nxt;
    logic       access;
    logic       in_range;

    assign access   = i_psel && i_penable;
    assign in_range = i_paddr < APB_AW'(DMEM_DEPTH);

    // Request only for a legal address in the access phase
    assign o_host_req   = (state == APB_ST_WAIT) && access && in_range;
    assign o_host_we    = i_pwrite;
    assign o_host_waddr = i_paddr[DMEM_AW-1:2];   // PADDR[1:0] ignored
    assign o_host_wdata = i_pwdata;
    assign o_host_strb  = i_pstrb;

    assign o_prdata = (state == APB_ST_RD_RET) ? i_host_rdata : '0;

    always_comb begin
        state_nxt = state;
        o_pready  = 1'b0;
        o_pslverr = 1'b0;
        case (state)
            APB_ST_IDLE: begin
                if (i_psel && !i_penable) begin
                    state_nxt = APB_ST_WAIT;   // Setup phase seen
                end
            end
            APB_ST_WAIT: begin
                if (!i_psel) begin
                    state_nxt = APB_ST_IDLE;
                end else if (access && !in_range) begin
                    o_pready  = 1'b1;
                    o_pslverr = 1'b1;
                    state_nxt = APB_ST_IDLE;
                end else if (access && i_grant) begin
                    if (i_pwrite) begin
                        o_pready  = 1'b1;      // Write lands on this edge
                        state_nxt = APB_ST_IDLE;
                    end else begin
                        state_nxt = APB_ST_RD_RET;
                    end
                end
            end
            APB_ST_RD_RET: begin
                o_pready  = access;
                state_nxt = APB_ST_IDLE;
            end
            default: state_nxt = APB_ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= APB_ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    a_pready_in_access: assert property (@(posedge clk) disable iff (i_rst)
        o_pready |-> (i_psel && i_penable));

endmodule

//--- hw/dmem/dmem_ram_ctrl.sv
/*
 * Byte-lane RAM with core-first arbitration
 * Synchronous word read, load byte/halfword select and extension
 */

`timescale 1ns/1ps

module dmem_ram_ctrl
    import dmem_cfg_pkg::*, rv_mem_pkg::*;
(
    input  logic                clk,
    input  logic                i_rst,
    input  logic [3:0]          i_core_lanes,
    input  mem_word_u           i_core_wdata,
    input  logic [DMEM_WAW-1:0] i_core_waddr,
    input  logic                i_core_rd_req,
    input  logic [1:0]          i_core_off,
    input  logic [2:0]          i_core_f3,
    input  logic                i_host_req,
    input  logic                i_host_we,
    input  logic [DMEM_WAW-1:0] i_host_addr,
    input  logic [APB_DW-1:0]   i_host_wdata,
    input  logic [APB_SW-1:0]   i_host_strb,
    output logic                o_grant,
    output logic [NB_WORD-1:0]  o_host_rdata,
    output logic [NB_WORD-1:0]  o_core_rdata,
    output logic                o_core_rvalid
);

    logic                core_req;
    logic [DMEM_WAW-1:0] addr;
    logic [3:0]          wr_lanes;
    mem_word_u           wr_word;
    logic                rd_en;
    logic [NB_BYTE-1:0]  rd_lane [4];
    mem_word_u           rd_word;
    logic [1:0]          ld_off_q;
    logic [2:0]          ld_f3_q;
    logic [NB_BYTE-1:0]  sel_b;
    logic [15:0]         sel_h;

    assign core_req = (|i_core_lanes) || i_core_rd_req;
    assign o_grant  = i_host_req && !core_req;   // Core always wins

    assign addr     = core_req ? i_core_waddr : i_host_addr;
    assign wr_word  = core_req ? i_core_wdata : mem_word_u'(i_host_wdata);
    assign wr_lanes = core_req ? i_core_lanes :
                      ((o_grant && i_host_we) ? i_host_strb : 4'b0000);
    assign rd_en    = i_core_rd_req || (o_grant && !i_host_we);

    for (genvar l = 0; l < 4; l++) begin : g_lane
        logic [NB_BYTE-1:0] mem [DMEM_WORDS];

        always_ff @(posedge clk) begin
            if (wr_lanes[l]) begin
                mem[addr] <= wr_word.b[l];
            end
        end

        always_ff @(posedge clk) begin
            if (i_rst) begin
                rd_lane[l] <= '0;
            end else if (rd_en) begin
                rd_lane[l] <= mem[addr];
            end
        end
    end

    always_comb begin
        for (int l = 0; l < 4; l++) begin
            rd_word.b[l] = rd_lane[l];
        end
    end

    assign o_host_rdata = rd_word;

    // Load shape travels with the read
    always_ff @(posedge clk) begin
        if (i_rst) begin
            ld_off_q      <= 2'b00;
            ld_f3_q       <= F3_LW;
            o_core_rvalid <= 1'b0;
        end else begin
            o_core_rvalid <= i_core_rd_req;
            if (i_core_rd_req) begin
                ld_off_q <= i_core_off;
                ld_f3_q  <= i_core_f3;
            end
        end
    end

    assign sel_b = rd_word.b[ld_off_q];
    assign sel_h = rd_word.h[ld_off_q[1]];

    always_comb begin
        case (ld_f3_q)
            F3_LB:   o_core_rdata = {{(NB_WORD-NB_BYTE){sel_b[NB_BYTE-1]}}, sel_b};
            F3_LBU:  o_core_rdata = {{(NB_WORD-NB_BYTE){1'b0}}, sel_b};
            F3_LH:   o_core_rdata = {{(NB_WORD-16){sel_h[15]}}, sel_h};
            F3_LHU:  o_core_rdata = {{(NB_WORD-16){1'b0}}, sel_h};
            default: o_core_rdata = rd_word;   // LW
        endcase
    end

    a_core_priority: assert property (@(posedge clk) disable iff (i_rst)
        core_req |-> !o_grant);

endmodule

//--- hw/dmem_top.sv
/*
 * Data memory top level
 * Core decoder and APB port feeding the RAM controller
 */

`timescale 1ns/1ps

module dmem_top
    import dmem_cfg_pkg::*, rv_mem_pkg::*;
(
    input  logic               clk,
    input  logic               i_rst,
    // Core side
    input  logic               i_core_ren,
    input  logic               i_core_wen,
    input  logic [2:0]         i_core_funct3,
    input  logic [DMEM_AW-1:0] i_core_addr,
    input  logic [NB_WORD-1:0] i_core_wdata,
    output logic [NB_WORD-1:0] o_core_rdata,
    output logic               o_core_rvalid,
    output logic               o_misaligned,
    // APB4 host
    input  logic               i_psel,
    input  logic               i_penable,
    input  logic               i_pwrite,
    input  logic [APB_AW-1:0]  i_paddr,
    input  logic [APB_DW-1:0]  i_pwdata,
    input  logic [APB_SW-1:0]  i_pstrb,
    output logic [APB_DW-1:0]  o_prdata,
    output logic               o_pready,
    output logic               o_pslverr
);

    logic [3:0]          core_lanes;
    mem_word_u           core_wdata;
    logic [DMEM_WAW-1:0] core_waddr;
    logic                core_rd_req;
    logic [1:0]          core_off;
    logic [2:0]          core_f3;
    logic                host_req;
    logic                host_we;
    logic [DMEM_WAW-1:0] host_addr;
    logic [APB_DW-1:0]   host_wdata;
    logic [APB_SW-1:0]   host_strb;
    logic                host_grant;
    logic [NB_WORD-1:0]  host_rdata;

    dmem_lsu_decode dmem_lsu_decode_inst (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_core_ren    (i_core_ren),
        .i_core_wen    (i_core_wen),
        .i_core_funct3 (i_core_funct3),
        .i_core_addr   (i_core_addr),
        .i_core_wdata  (i_core_wdata),
        .o_wr_lanes    (core_lanes),
        .o_wr_data     (core_wdata),
        .o_word_addr   (core_waddr),
        .o_rd_req      (core_rd_req),
        .o_byte_off    (core_off),
        .o_ld_funct3   (core_f3),
        .o_misaligned  (o_misaligned)
    );

    dmem_apb_port dmem_apb_port_inst (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .i_pstrb      (i_pstrb),
        .i_grant      (host_grant),
        .i_host_rdata (host_rdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .o_host_req   (host_req),
        .o_host_we    (host_we),
        .o_host_waddr (host_addr),
        .o_host_wdata (host_wdata),
        .o_host_strb  (host_strb)
    );

    dmem_ram_ctrl dmem_ram_ctrl_inst (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_core_lanes  (core_lanes),
        .i_core_wdata  (core_wdata),
        .i_core_waddr  (core_waddr),
        .i_core_rd_req (core_rd_req),
        .i_core_off    (core_off),
        .i_core_f3     (core_f3),
        .i_host_req    (host_req),
        .i_host_we     (host_we),
        .i_host_addr   (host_addr),
        .i_host_wdata  (host_wdata),
        .i_host_strb   (host_strb),
        .o_grant       (host_grant),
        .o_host_rdata  (host_rdata),
        .o_core_rdata  (o_core_rdata),
        .o_core_rvalid (o_core_rvalid)
    );

endmodule

//--- verification/dmem_tb_model.svh
/*
 * Galois LFSR stimulus source
 * Shadow byte memory with store, strobe write and load extension helpers
 */

`ifndef DMEM_TB_MODEL_SVH
`define DMEM_TB_MODEL_SVH

logic [31:0] lfsr_state = 32'he4ed;
logic [7:0]  shadow [DMEM_DEPTH];

// One LFSR step per bit taken
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        lsb;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lsb        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        r = {r[30:0], lsb};
    end
    return r;
endfunction

function automatic logic [31:0] shadow_word(input logic [7:0] a);
    logic [7:0] base;
    base = {a[7:2], 2'b00};
    return {shadow[base + 8'd3], shadow[base + 8'd2], shadow[base + 8'd1], shadow[base]};
endfunction

// Expected load result, little-endian lanes
function automatic logic [31:0] extend_load(input logic [2:0] f3, input logic [7:0] a);
    logic [7:0]  bt;
    logic [15:0] hw;
    bt = shadow[a];
    hw = {shadow[{a[7:1], 1'b1}], shadow[{a[7:1], 1'b0}]};
    case (f3)
        F3_LB:   return {{24{bt[7]}}, bt};
        F3_LBU:  return {24'h0, bt};
        F3_LH:   return {{16{hw[15]}}, hw};
        F3_LHU:  return {16'h0, hw};
        default: return shadow_word(a);
    endcase
endfunction

task automatic shadow_store(input logic [2:0] f3, input logic [7:0] a, input logic [31:0] d);
    case (f3)
        F3_SB: shadow[a] = d[7:0];
        F3_SH: begin
            shadow[a]        = d[7:0];
            shadow[a + 8'd1] = d[15:8];
        end
        default: begin
            for (int i = 0; i < 4; i++) begin
                shadow[a + 8'(i)] = d[8*i +: 8];
            end
        end
    endcase
endtask

task automatic shadow_strobe_write(input logic [7:0] a, input logic [31:0] d,
                                   input logic [3:0] strb);
    for (int i = 0; i < 4; i++) begin
        if (strb[i]) begin
            shadow[{a[7:2], 2'b00} + 8'(i)] = d[8*i +: 8];
        end
    end
endtask

`endif

//--- verification/dmem_tb.sv
/*
 * Data memory testbench
 * Core and APB stimulus, concurrent checks against a shadow model
 */

`timescale 1ns/1ps

module dmem_tb
    import dmem_cfg_pkg::*, rv_mem_pkg::*;
();

    `include "dmem_tb_model.svh"

    localparam int APB_LIMIT = 64;
    localparam int T_CYCLES  = (DMEM_WORDS + 2) + 24 * 4 + 4 * 14 + 12 + 8 * 12 + 40 + 30;
    localparam int WD_NS     = (T_CYCLES + 3 + 200) * 40;   // Sum of tests plus margin

    logic        clk;
    logic        i_rst;
    logic        i_core_ren, i_core_wen;
    logic [2:0]  i_core_funct3;
    logic [7:0]  i_core_addr;
    logic [31:0] i_core_wdata, o_core_rdata;
    logic        o_core_rvalid, o_misaligned;
    logic        i_psel, i_penable, i_pwrite;
    logic [11:0] i_paddr;
    logic [31:0] i_pwdata, o_prdata;
    logic [3:0]  i_pstrb;
    logic        o_pready, o_pslverr;

    // Expectations travel with the stimulus
    logic        exp_ld, exp_mis, exp_mis_q, apb_exp_err;
    logic [31:0] exp_data, exp_data_q, apb_exp_data;

    int error_count = 0;
    int tests_run   = 0;
    int tests_ok    = 0;

    dmem_top dmem_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        exp_data_q <= exp_data;
        exp_mis_q  <= exp_mis;
    end

    a_reset_vals: assert property (@(posedge clk) $fell(i_rst) |->
        (!o_pready && !o_pslverr && !o_core_rvalid && !o_misaligned && o_core_rdata == 0))
        else begin
            $display("Outputs not at their reset values after reset");
            error_count++;
        end

    a_ld_latency: assert property (@(posedge clk) disable iff (i_rst)
        exp_ld |=> o_core_rvalid)
        else begin
            $display("MISMATCH o_core_rvalid exp=1 got=%h", $sampled(o_core_rvalid));
            error_count++;
        end

    a_no_rvalid: assert property (@(posedge clk) disable iff (i_rst)
        !exp_ld |=> !o_core_rvalid)
        else begin
            $display("MISMATCH o_core_rvalid exp=0 got=%h", $sampled(o_core_rvalid));
            error_count++;
        end

    a_ld_data: assert property (@(posedge clk) disable iff (i_rst)
        exp_ld |=> (o_core_rdata == exp_data_q))
        else begin
            $display("MISMATCH o_core_rdata exp=%h got=%h",
                     $sampled(exp_data_q), $sampled(o_core_rdata));
            error_count++;
        end

    a_mis_flag: assert property (@(posedge clk) disable iff (i_rst)
        o_misaligned == exp_mis_q)
        else begin
            $display("MISMATCH o_misaligned exp=%h got=%h",
                     $sampled(exp_mis_q), $sampled(o_misaligned));
            error_count++;
        end

    a_apb_err: assert property (@(posedge clk) disable iff (i_rst)
        o_pready |-> (o_pslverr == apb_exp_err))
        else begin
            $display("MISMATCH o_pslverr exp=%h got=%h",
                     $sampled(apb_exp_err), $sampled(o_pslverr));
            error_count++;
        end

    a_apb_rdata: assert property (@(posedge clk) disable iff (i_rst)
        (o_pready && !i_pwrite && !apb_exp_err) |-> (o_prdata == apb_exp_data))
        else begin
            $display("MISMATCH o_prdata exp=%h got=%h",
                     $sampled(apb_exp_data), $sampled(o_prdata));
            error_count++;
        end

    a_apb_phase: assert property (@(posedge clk) disable iff (i_rst)
        o_pready |-> (i_psel && i_penable))
        else begin
            $display("APB ready raised outside the access phase");
            error_count++;
        end

    // Host writes wait out core traffic and reads need a free cycle first
    a_apb_stall: assert property (@(posedge clk) disable iff (i_rst)
        (o_pready && !apb_exp_err) |->
            (i_pwrite ? !i_core_ren : !$past(i_core_ren)))
        else begin
            $display("APB transfer completed while the core held the RAM");
            error_count++;
        end

    // Idle core, so a write lands in the access cycle itself
    a_apb_wr_prompt: assert property (@(posedge clk) disable iff (i_rst)
        (i_psel && i_penable && i_pwrite && !i_core_ren && !i_core_wen) |-> o_pready)
        else begin
            $display("APB write not completed although the core was idle");
            error_count++;
        end

    a_apb_rd_prompt: assert property (@(posedge clk) disable iff (i_rst)
        (i_psel && i_penable && !i_pwrite && !o_pready && !i_core_ren && !i_core_wen)
            |=> o_pready)
        else begin
            $display("APB read not completed one cycle after a free RAM cycle");
            error_count++;
        end

    // Natural alignment, address a multiple of the access size
    function automatic logic is_misaligned(input logic [2:0] f3, input logic [7:0] a);
        return (a & ((8'd1 << f3[1:0]) - 8'd1)) != 8'd0;
    endfunction

    task automatic core_op(input logic ren, input logic wen, input logic [2:0] f3,
                           input logic [7:0] a, input logic [31:0] d);
        logic mis;
        mis = is_misaligned(f3, a);
        @(posedge clk);
        i_core_ren    <= ren;
        i_core_wen    <= wen;
        i_core_funct3 <= f3;
        i_core_addr   <= a;
        i_core_wdata  <= d;
        exp_ld        <= ren && !mis;
        exp_mis       <= (ren || wen) && mis;
        exp_data      <= extend_load(f3, a);
        if (wen && !mis) begin
            shadow_store(f3, a, d);
        end
    endtask

    task automatic core_idle();
        @(posedge clk);
        i_core_ren <= 1'b0;
        i_core_wen <= 1'b0;
        exp_ld     <= 1'b0;
        exp_mis    <= 1'b0;
    endtask

    task automatic apb_xfer(input logic wr, input logic [11:0] a, input logic [31:0] d,
                            input logic [3:0] strb, output int waited);
        logic err;
        int   n;
        err = (a >= 12'(DMEM_DEPTH));
        n   = 0;
        @(posedge clk);
        i_psel       <= 1'b1;
        i_penable    <= 1'b0;
        i_pwrite     <= wr;
        i_paddr      <= a;
        i_pwdata     <= d;
        i_pstrb      <= strb;
        apb_exp_err  <= err;
        apb_exp_data <= shadow_word(a[7:0]);
        @(posedge clk);
        i_penable <= 1'b1;
        @(negedge clk);
        while (!o_pready && n < APB_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!o_pready) begin
            $display("APB transfer to %h never completed", a);
            error_count++;
        end
        @(posedge clk);
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
        if (wr && !err) begin
            shadow_strobe_write(a[7:0], d, strb);
        end
        waited = n;
    endtask

    task automatic end_test(input string name, input int errs_before);
        @(negedge clk);   // Let checks of the last edge report first
        tests_run++;
        if (error_count == errs_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, error_count - errs_before);
        end
    endtask

    initial begin
        #(WD_NS);
        $display("Watchdog expired after %0d ns, run stopped", WD_NS);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int         e;
        int         w;
        logic [7:0] a;
        logic [2:0] f3;
        logic [3:0] st;
        i_rst = 1'b1;
        i_core_ren = 1'b0;
        i_core_wen = 1'b0;
        i_core_funct3 = 3'b000;
        i_core_addr = '0;
        i_core_wdata = '0;
        i_psel = 1'b0;
        i_penable = 1'b0;
        i_pwrite = 1'b0;
        i_paddr = '0;
        i_pwdata = '0;
        i_pstrb = '0;
        exp_ld = 1'b0;
        exp_mis = 1'b0;
        exp_data = '0;
        apb_exp_err = 1'b0;
        apb_exp_data = '0;
        repeat (3) @(posedge clk);
        i_rst <= 1'b0;

        e = error_count;   // Fill pattern from the whole address
        for (int i = 0; i < DMEM_DEPTH; i += 4) begin
            core_op(0, 1, F3_SW, 8'(i), {8'(i + 3) ^ 8'h96, 8'(i + 2) ^ 8'h3c,
                                         8'(i + 1) ^ 8'he1, 8'(i) ^ 8'h5a});
        end
        core_idle();
        end_test("fill", e);

        e = error_count;
        for (int i = 0; i < 24; i++) begin
            f3 = 3'(take_bits(2) % 3);
            a  = 8'(take_bits(8));
            a  = (f3 == F3_SW) ? {a[7:2], 2'b00} : (f3 == F3_SH) ? {a[7:1], 1'b0} : a;
            core_op(0, 1, f3, a, take_bits(32));
            core_op(1, 0, F3_LW, {a[7:2], 2'b00}, '0);
            core_idle();
        end
        end_test("store_merge", e);

        e = error_count;
        for (int i = 0; i < 4; i++) begin
            a = {6'(take_bits(6)), 2'b00};
            for (int o = 0; o < 4; o++) begin
                core_op(1, 0, F3_LB, a + 8'(o), '0);
                core_op(1, 0, F3_LBU, a + 8'(o), '0);
            end
            for (int o = 0; o < 4; o += 2) begin
                core_op(1, 0, F3_LH, a + 8'(o), '0);
                core_op(1, 0, F3_LHU, a + 8'(o), '0);
            end
            core_idle();
        end
        end_test("load_extend", e);

        e = error_count;
        core_op(1, 0, F3_LH, 8'h21, '0);
        core_op(1, 0, F3_LW, 8'h42, '0);
        core_op(0, 1, F3_SH, 8'h63, 32'hdead_beef);
        core_op(0, 1, F3_SW, 8'h85, 32'hcafe_f00d);
        core_op(1, 0, F3_LW, 8'h60, '0);
        core_op(1, 0, F3_LW, 8'h64, '0);
        core_op(1, 0, F3_LW, 8'h84, '0);
        core_op(1, 0, F3_LW, 8'h88, '0);
        core_idle();
        end_test("misaligned", e);

        e = error_count;
        for (int i = 0; i < 8; i++) begin
            a  = 8'(take_bits(8));
            st = 4'(take_bits(4));
            apb_xfer(1, {4'h0, a}, take_bits(32), st, w);
            apb_xfer(0, {4'h0, a}, '0, 4'h0, w);
            core_op(1, 0, F3_LW, {a[7:2], 2'b00}, '0);
            core_idle();
        end
        end_test("apb_strobe", e);

        e = error_count;
        fork
            begin
                for (int i = 0; i < 14; i++) begin
                    core_op(1, 0, F3_LW, 8'(4 * i), '0);
                end
                core_idle();
            end
            begin
                repeat (2) @(posedge clk);
                apb_xfer(1, 12'h0a4, 32'h1234_5678, 4'hf, w);
                if (w < 3) begin
                    $display("APB write was not held off by core loads");
                    error_count++;
                end
                apb_xfer(0, 12'h0a4, '0, 4'h0, w);
            end
        join
        end_test("apb_backpressure", e);

        e = error_count;
        apb_xfer(1, 12'h1a8, 32'hffff_ffff, 4'hf, w);
        apb_xfer(0, 12'hfa8, '0, 4'h0, w);
        apb_xfer(0, 12'h0a8, '0, 4'h0, w);
        core_op(1, 0, F3_LW, 8'ha8, '0);
        core_idle();
        end_test("apb_range", e);

        repeat (2) @(posedge clk);
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_ok, tests_run - tests_ok, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verification
common/dmem_cfg_pkg.sv
common/rv_mem_pkg.sv
hw/dmem/dmem_lsu_decode.sv
hw/dmem/dmem_apb_port.sv
hw/dmem/dmem_ram_ctrl.sv
hw/dmem_top.sv
verification/dmem_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing
TOP       ?= dmem_tb
RTL_TOP   ?= dmem_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^\*\* PASS \*\*$$'

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
